//--- Bender.yml
package:
  name: single_cpu

sources:
  - hdl/rvPkg.sv
  - hdl/instMem.sv
  - hdl/regFile.sv
  - hdl/dataMem.sv
  - hdl/decoder.sv
  - hdl/alu.sv
  - hdl/singleCpu.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/singleCpuTb.sv

//--- compile.f
hdl/rvPkg.sv
hdl/instMem.sv
hdl/regFile.sv
hdl/dataMem.sv
hdl/decoder.sv
hdl/alu.sv
hdl/singleCpu.sv
testbench/clockGen.sv
testbench/singleCpuTb.sv

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu
    import rvPkg::*;
(
    input  wordT  a,
    input  wordT  b,
    input  aluOpT op,
    output wordT  result,
    output logic  zero    // Used by beq and bne
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only the low five bits shift

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- hdl/dataMem.sv
`timescale 1ns/1ps

module dataMem
    import rvPkg::*;
(
    input  logic CLK,
    input  logic we,
    input  wordT addr,   // Byte address, word aligned
    input  wordT wdata,
    output wordT rdata
);

    wordT mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] wordAddr;

    // Drop the byte offset
    assign wordAddr = addr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordAddr] <= wdata;
        end
    end

    assign rdata = mem[wordAddr];

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder
    import rvPkg::*;
(
    input  wordT   instr,
    output regIdxT rs1,
    output regIdxT rs2,
    output regIdxT rd,
    output wordT   imm,
    output aluOpT  aluOp,
    output logic   aluSrcImm,  // Operand B from immediate
    output logic   regWrite,
    output logic   memWrite,
    output logic   memToReg,   // Writeback from data memory
    output logic   branch,
    output logic   branchNe    // bne rather than beq
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    immSelT     immSel;

    // Shared funct3 map for R-type and I-type
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3);
        case (f3)
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b100:  return aluXor;
            3'b101:  return aluSrl;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // Main control
    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        immSel    = immI;
        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                if (funct3 == 3'b000 && funct7b5) begin
                    aluOp = aluSub;
                end else begin
                    aluOp = aluFromFunct3(funct3);
                end
            end
            opImm: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluFromFunct3(funct3);
            end
            opLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
            end
            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSel    = immS;
            end
            opBranch: begin
                aluOp    = aluSub;  // Zero flag means equal
                immSel   = immB;
                branch   = (funct3[2:1] == 2'b00);  // Only beq and bne
                branchNe = funct3[0];
            end
            opLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluPassB;
                immSel    = immU;
            end
            default: ;  // Unknown opcode acts as a nop
        endcase
    end

    // Sign-extended immediate
    always_comb begin
        case (immSel)
            immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            immU:    imm = {instr[31:12], 12'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

//--- hdl/instMem.sv
`timescale 1ns/1ps

module instMem
    import rvPkg::*;
(
    input  logic               CLK,
    input  logic               we,        // Host program load
    input  logic [IMEM_AW-1:0] loadAddr,
    input  wordT               loadData,
    input  logic [IMEM_AW-1:0] addr,      // Fetch word address
    output wordT               rdata
);

    wordT mem [IMEM_WORDS];

    // Program load from the host
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign rdata = mem[addr];  // Fetch is combinational

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile
    import rvPkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  logic   we,
    input  wordT   wdata,
    output wordT   rdata1,
    output wordT   rdata2
);

    // x0 has no storage
    wordT regs [31:1];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;  // Writes to x0 dropped
        end
    end

    // Reads are combinational, x0 always zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

    // Memory sizes in 32-bit words
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    typedef logic [31:0] wordT;   // Data, address or instruction word
    typedef logic [4:0] regIdxT;  // Register file index

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8   // lui
    } aluOpT;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111
    } opcodeT;

    // Immediate formats
    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2,
        immU = 2'd3
    } immSelT;

endpackage

//--- hdl/singleCpu.sv
`timescale 1ns/1ps

module singleCpu
    import rvPkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    // Host program load, honored during reset
    input  logic               progWe,
    input  logic [IMEM_AW-1:0] progAddr,
    input  wordT               progData,
    // Observation of the current instruction
    output wordT               pc,
    output wordT               instr,
    output logic               wbEn,
    output regIdxT             wbReg,
    output wordT               wbData,
    output logic               memWe,
    output wordT               memAddr,
    output wordT               memWdata
);

    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    wordT   imm;
    aluOpT  aluOp;
    logic   aluSrcImm;
    logic   regWrite;
    logic   memWrite;
    logic   memToReg;
    logic   branch;
    logic   branchNe;

    wordT   rs1Data;
    wordT   rs2Data;
    wordT   aluB;
    wordT   aluResult;
    logic   aluZero;
    wordT   memRdata;
    logic   takeBranch;
    wordT   nextPc;

    instMem uInstMem (
        .CLK      (CLK),
        .we       (progWe && RST),
        .loadAddr (progAddr),
        .loadData (progData),
        .addr     (pc[IMEM_AW+1:2]),
        .rdata    (instr)
    );

    decoder uDecoder (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .aluOp     (aluOp),
        .aluSrcImm (aluSrcImm),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .memToReg  (memToReg),
        .branch    (branch),
        .branchNe  (branchNe)
    );

    regFile uRegFile (
        .CLK    (CLK),
        .RST    (RST),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (wbEn),
        .wdata  (wbData),
        .rdata1 (rs1Data),
        .rdata2 (rs2Data)
    );

    assign aluB = aluSrcImm ? imm : rs2Data;

    alu uAlu (
        .a      (rs1Data),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMem uDataMem (
        .CLK   (CLK),
        .we    (memWe),
        .addr  (aluResult),
        .wdata (rs2Data),
        .rdata (memRdata)
    );

    // Writes are held off while the host loads the program
    assign wbEn     = regWrite && !RST;
    assign wbReg    = rd;
    assign wbData   = memToReg ? memRdata : aluResult;
    assign memWe    = memWrite && !RST;
    assign memAddr  = aluResult;
    assign memWdata = rs2Data;

    // beq on zero, bne on non-zero
    assign takeBranch = branch && (branchNe ? !aluZero : aluZero);
    assign nextPc     = takeBranch ? (pc + imm) : (pc + 32'd4);

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Released on a falling edge
    initial begin
        RST = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
    end

endmodule

//--- testbench/cpuVectors.txt
# C  count of P lines  count of T lines
# P  word address  instruction word (hex)
# T  test  pc  wbEn  wbReg  wbData  memWe  memAddr  memWdata (hex, - is don't care)
C 32 33
P 00 00C00093  # addi x1, x0, 12
P 01 FFB00113  # addi x2, x0, -5
P 02 002081B3  # add  x3, x1, x2
P 03 40208233  # sub  x4, x1, x2
P 04 0020F2B3  # and  x5, x1, x2
P 05 0020E333  # or   x6, x1, x2
P 06 0020C3B3  # xor  x7, x1, x2
P 07 00112433  # slt  x8, x2, x1
P 08 0020A4B3  # slt  x9, x1, x2
P 09 00309533  # sll  x10, x1, x3
P 0A 003155B3  # srl  x11, x2, x3
P 0B 0F017613  # andi x12, x2, 0xf0
P 0C 7000E693  # ori  x13, x1, 0x700
P 0D FFF0C713  # xori x14, x1, -1
P 0E FFC12793  # slti x15, x2, -4
P 0F 12345837  # lui  x16, 0x12345
P 10 0040A423  # sw   x4, 8(x1)
P 11 01002223  # sw   x16, 4(x0)
P 12 0080A883  # lw   x17, 8(x1)
P 13 00402903  # lw   x18, 4(x0)
P 14 03700013  # addi x0, x0, 55
P 15 00300A33  # add  x20, x0, x3
P 16 00488463  # beq  x17, x4, +8
P 17 06300993  # addi x19, x0, 99
P 18 00209463  # bne  x1, x2, +8
P 19 04D00993  # addi x19, x0, 77
P 1A 00208463  # beq  x1, x2, +8
P 1B 00489463  # bne  x17, x4, +8
P 1C 001A8A93  # addi x21, x21, 1
P 1D 002AAB13  # slti x22, x21, 2
P 1E FE0B1CE3  # bne  x22, x0, -8
P 1F 00000063  # beq  x0, x0, 0
T 1 00000004 1 02 FFFFFFFB 0 - -
T 2 00000008 1 03 00000007 0 - -
T 2 0000000C 1 04 00000011 0 - -
T 2 00000010 1 05 00000008 0 - -
T 2 00000014 1 06 FFFFFFFF 0 - -
T 2 00000018 1 07 FFFFFFF7 0 - -
T 2 0000001C 1 08 00000001 0 - -
T 2 00000020 1 09 00000000 0 - -
T 2 00000024 1 0A 00000600 0 - -
T 2 00000028 1 0B 01FFFFFF 0 - -
T 2 0000002C 1 0C 000000F0 0 - -
T 2 00000030 1 0D 0000070C 0 - -
T 2 00000034 1 0E FFFFFFF3 0 - -
T 2 00000038 1 0F 00000001 0 - -
T 2 0000003C 1 10 12345000 0 - -
T 3 00000040 0 -  -        1 00000014 00000011
T 3 00000044 0 -  -        1 00000004 12345000
T 3 00000048 1 11 00000011 0 - -
T 3 0000004C 1 12 12345000 0 - -
T 4 00000050 1 00 00000037 0 - -
T 4 00000054 1 14 00000007 0 - -
T 5 00000058 0 -  -        0 - -
T 5 00000060 0 -  -        0 - -
T 5 00000068 0 -  -        0 - -
T 5 0000006C 0 -  -        0 - -
T 5 00000070 1 15 00000001 0 - -
T 5 00000074 1 16 00000001 0 - -
T 5 00000078 0 -  -        0 - -
T 5 00000070 1 15 00000002 0 - -
T 5 00000074 1 16 00000000 0 - -
T 5 00000078 0 -  -        0 - -
T 5 0000007C 0 -  -        0 - -
T 5 0000007C 0 -  -        0 - -

//--- testbench/singleCpuTb.sv
`timescale 1ns/1ps

module singleCpuTb
    import rvPkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 128;
    localparam int FIELDS       = 7;

    logic               CLK;
    logic               rstGen;
    logic               hostLoad;  // Keeps RST high until the program is in
    logic               RST;
    logic               progWe;
    logic [IMEM_AW-1:0] progAddr;
    wordT               progData;
    wordT               pc;
    wordT               instr;
    logic               wbEn;
    regIdxT             wbReg;
    wordT               wbData;
    logic               memWe;
    wordT               memAddr;
    wordT               memWdata;

    // Vector file contents
    int   progAt [MAX_LINES];
    wordT progWord [MAX_LINES];
    int   traceTest [MAX_LINES];
    wordT expVal [MAX_LINES][FIELDS];
    logic expCare [MAX_LINES][FIELDS];  // Low for a dash
    int   numP;
    int   numT;
    int   wantP;
    int   wantT;
    bit   vectorsOk;
    bit   vectorsReady;

    string fieldName [FIELDS] = '{"pc", "wbEn", "wbReg", "wbData", "memWe", "memAddr",
                                  "memWdata"};
    string testName [1:5] = '{"reset and first fetch", "ALU writeback", "store and load",
                              "x0 handling", "branches"};

    int checks;
    int errors;
    int testsDone;
    int startChecks;
    int startErrors;

    assign RST = rstGen || hostLoad;

    clockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) uClockGen (
        .CLK (CLK),
        .RST (rstGen)
    );

    singleCpu UUT (
        .CLK      (CLK),
        .RST      (RST),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

    task automatic readVectors(output bit ok);
        int    fd;
        int    n;
        int    i;
        int    testNo;
        int    addr;
        wordT  word;
        string line;
        string kind;
        string f [FIELDS];
        ok = 1'b0;
        fd = $fopen("testbench/cpuVectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file testbench/cpuVectors.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            kind = "";
            n = $sscanf(line, "%s", kind);
            if (kind == "C") begin
                n = $sscanf(line, "%s %d %d", kind, wantP, wantT);
            end else if (kind == "P" && numP < MAX_LINES) begin
                n = $sscanf(line, "%s %h %h", kind, addr, word);
                if (n == 3) begin
                    progAt[numP] = addr;
                    progWord[numP] = word;
                    numP++;
                end
            end else if (kind == "T" && numT < MAX_LINES) begin
                n = $sscanf(line, "%s %d %s %s %s %s %s %s %s", kind, testNo,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (n == 9) begin
                    traceTest[numT] = testNo;
                    for (i = 0; i < FIELDS; i++) begin
                        expVal[numT][i] = '0;
                        expCare[numT][i] = (f[i] != "-");
                        n = $sscanf(f[i], "%h", expVal[numT][i]);
                    end
                    numT++;
                end
            end
        end
        $fclose(fd);
        if (wantP == 0 || numP < wantP || numT < wantT) begin
            $display("Vector file holds %0d program and %0d trace lines, expected %0d and %0d",
                     numP, numT, wantP, wantT);
        end else begin
            ok = 1'b1;
        end
    endtask

    task automatic checkValue(input string what, input wordT expected, input wordT got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0d ns: %s expected %h got %h", $time, what, expected, got);
        end
    endtask

    task automatic checkResetState();
        checkValue("pc in reset", '0, pc);
        checkValue("wbEn in reset", '0, wbEn);
        checkValue("memWe in reset", '0, memWe);
    endtask

    task automatic reportTest(input int num);
        testsDone++;
        $display("Test %0d, %s: %0d checks, %0d errors", num, testName[num],
                 checks - startChecks, errors - startErrors);
        startChecks = checks;
        startErrors = errors;
    endtask

    // One word per falling edge while RST is high
    task automatic loadProgram();
        int   k;
        wordT firstWord;
        firstWord = 'x;
        for (k = 0; k < numP; k++) begin
            @(negedge CLK);
            checkResetState();
            progWe = 1'b1;
            progAddr = progAt[k][IMEM_AW-1:0];
            progData = progWord[k];
            if (progAt[k] == 0) begin
                firstWord = progWord[k];
            end
        end
        wait (rstGen == 1'b0);
        @(negedge CLK);
        checkResetState();
        checkValue("instr at address 0", firstWord, instr);
        progWe = 1'b0;
        hostLoad = 1'b0;
    endtask

    task automatic runTrace();
        int   k;
        int   i;
        wordT got [FIELDS];
        for (k = 0; k < numT; k++) begin
            @(negedge CLK);
            got[0] = pc;
            got[1] = wbEn;
            got[2] = wbReg;
            got[3] = wbData;
            got[4] = memWe;
            got[5] = memAddr;
            got[6] = memWdata;
            for (i = 0; i < FIELDS; i++) begin
                if (expCare[k][i]) begin
                    checkValue($sformatf("%s at pc %h", fieldName[i], expVal[k][0]),
                               expVal[k][i], got[i]);
                end
            end
            if (k == numT - 1 || traceTest[k + 1] != traceTest[k]) begin
                reportTest(traceTest[k]);
            end
        end
    endtask

    initial begin
        hostLoad = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        readVectors(vectorsOk);
        if (!vectorsOk) begin
            $display("test failed");
            $finish;
        end else begin
            vectorsReady = 1'b1;
            loadProgram();
            runTrace();
            $display("%0d tests, %0d checks, %0d errors", testsDone, checks, errors);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

    // Watchdog sized from the vector counts
    initial begin
        wait (vectorsReady);
        #((RESET_CYCLES + numP + numT + 20) * CLK_PERIOD);
        $display("The run timed out before the trace finished");
        $display("test failed");
        $finish;
    end

endmodule
